// File: lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;  // data, address and instruction
	typedef logic [2:0]  lc3b_reg;   // register number
	typedef logic [2:0]  lc3b_nzp;   // n, z, p

	// only the opcodes this core implements get a name
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass  // b straight through
	} lc3b_aluop;

	typedef enum logic [1:0] {
		fwd_none,  // value from the ID/EX register
		fwd_mem,
		fwd_wb
	} lc3b_fwd_sel;

	// second alu operand
	typedef enum logic [1:0] {
		alub_reg,
		alub_imm5,
		alub_off6w,  // offset6 scaled to words
		alub_off6b
	} lc3b_alub_sel;

	typedef enum logic {
		rf_alu,
		rf_mem
	} lc3b_regfile_sel;

	typedef struct packed {
		lc3b_opcode      opcode;
		lc3b_aluop       aluop;
		lc3b_alub_sel    alu_b_sel;
		logic            load_regfile;
		logic            load_cc;
		logic            mem_read;
		logic            mem_write;
		logic            mem_byte;
		lc3b_regfile_sel regfile_sel;
		logic            is_branch;   // BR with at least one nzp bit
		logic            valid_dest;  // dest field names a written register
		logic            uses_src2;
		logic            store_src;   // second read port takes bits 11:9
	} lc3b_control_word;

endpackage

// File: mem_stage_if.sv
`timescale 1ns/1ns

interface mem_stage_if import lc3b_types::*; ();

	lc3b_control_word ctrl;
	logic             valid;       // live instruction in MEM
	lc3b_word         alu_data;    // effective address
	lc3b_word         src_data;    // store data
	logic             advance;
	lc3b_word         mem_output;  // load result, bytes zero-extended
	logic             ready;

	modport datapath (
		output ctrl, valid, alu_data, src_data, advance,
		input  mem_output, ready
	);

	modport mem (
		input  ctrl, valid, alu_data, src_data, advance,
		output mem_output, ready
	);

endinterface

// File: control_rom.sv
`timescale 1ns/1ns

module control_rom import lc3b_types::*; (
	input  lc3b_word         i_instr,
	output lc3b_control_word o_ctrl
);

	always_comb begin
		o_ctrl = '0;  // no writes, no memory access
		o_ctrl.opcode = lc3b_opcode'(i_instr[15:12]);
		o_ctrl.aluop = alu_add;
		o_ctrl.alu_b_sel = alub_reg;
		o_ctrl.regfile_sel = rf_alu;

		case (o_ctrl.opcode)
			op_add, op_and: begin
				o_ctrl.aluop = (o_ctrl.opcode == op_and) ? alu_and : alu_add;
				// bit 5 picks imm5 over sr2
				o_ctrl.alu_b_sel = i_instr[5] ? alub_imm5 : alub_reg;
				o_ctrl.uses_src2 = ~i_instr[5];
				o_ctrl.load_regfile = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.valid_dest = 1'b1;
			end
			op_not: begin
				o_ctrl.aluop = alu_not;
				o_ctrl.load_regfile = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.valid_dest = 1'b1;
			end
			op_ldr, op_ldb: begin
				o_ctrl.alu_b_sel = (o_ctrl.opcode == op_ldb) ? alub_off6b : alub_off6w;
				o_ctrl.mem_read = 1'b1;
				o_ctrl.mem_byte = (o_ctrl.opcode == op_ldb);
				o_ctrl.regfile_sel = rf_mem;
				o_ctrl.load_regfile = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.valid_dest = 1'b1;
			end
			op_str, op_stb: begin
				o_ctrl.alu_b_sel = (o_ctrl.opcode == op_stb) ? alub_off6b : alub_off6w;
				o_ctrl.mem_write = 1'b1;
				o_ctrl.mem_byte = (o_ctrl.opcode == op_stb);
				o_ctrl.store_src = 1'b1;  // store data comes from the sr field
			end
			op_br: begin
				o_ctrl.aluop = alu_pass;
				o_ctrl.is_branch = |i_instr[11:9];  // nzp all clear is a nop
			end
			default: begin
				// unsupported opcode passes down as a bubble
			end
		endcase
	end

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile import lc3b_types::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_load,
	input  lc3b_reg  i_dest,
	input  lc3b_word i_data,
	input  lc3b_reg  i_src_a,
	input  lc3b_reg  i_src_b,
	output lc3b_word o_reg_a,
	output lc3b_word o_reg_b
);

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (i_load) begin
			regs[i_dest] <= i_data;
		end
	end

	// write-through so ID never picks up the old value
	assign o_reg_a = (i_load && i_dest == i_src_a) ? i_data : regs[i_src_a];
	assign o_reg_b = (i_load && i_dest == i_src_b) ? i_data : regs[i_src_b];

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu import lc3b_types::*; (
	input  lc3b_aluop i_aluop,
	input  lc3b_word  i_a,
	input  lc3b_word  i_b,
	output lc3b_word  o_f
);

	always_comb begin
		case (i_aluop)
			alu_add: begin
				o_f = i_a + i_b;  // also forms load/store addresses
			end
			alu_and: begin
				o_f = i_a & i_b;
			end
			alu_not: begin
				o_f = ~i_a;
			end
			alu_pass: begin
				o_f = i_b;
			end
			default: begin
				o_f = i_b;
			end
		endcase
	end

endmodule

// File: dataforward.sv
`timescale 1ns/1ns

module dataforward import lc3b_types::*; (
	input  lc3b_reg     i_ex_src1,
	input  lc3b_reg     i_ex_src2,
	input  lc3b_reg     i_mem_dest,
	input  lc3b_reg     i_wb_dest,
	input  logic        i_mem_valid_dest,
	input  logic        i_wb_valid_dest,
	output lc3b_fwd_sel o_sel1,
	output lc3b_fwd_sel o_sel2
);

	function automatic lc3b_fwd_sel pick(
		input lc3b_reg src,
		input lc3b_reg mem_dest,
		input logic    mem_valid,
		input lc3b_reg wb_dest,
		input logic    wb_valid
	);
		// the younger result in MEM wins over WB
		if (mem_valid && mem_dest == src)
			return fwd_mem;
		if (wb_valid && wb_dest == src)
			return fwd_wb;
		return fwd_none;
	endfunction

	always_comb begin
		o_sel1 = pick(i_ex_src1, i_mem_dest, i_mem_valid_dest, i_wb_dest, i_wb_valid_dest);
		// src2 is either sr2 or the store register
		o_sel2 = pick(i_ex_src2, i_mem_dest, i_mem_valid_dest, i_wb_dest, i_wb_valid_dest);
	end

endmodule

// File: mem_control.sv
`timescale 1ns/1ns

module mem_control import lc3b_types::*; (
	input  logic       clk,
	input  logic       i_reset,
	mem_stage_if.mem   mem_bus,
	input  lc3b_word   i_mem_rdata,
	input  logic       i_data_response,
	output lc3b_word   o_mem_address,
	output lc3b_word   o_write_data,
	output logic [1:0] o_mem_byte_enable,
	output logic       o_data_request,
	output logic       o_write_enable
);

	logic       access;
	logic       resp_seen;  // access done but pipe still frozen
	lc3b_word   held_rdata;
	lc3b_word   rdata;
	logic [7:0] rbyte;

	assign access = mem_bus.valid & (mem_bus.ctrl.mem_read | mem_bus.ctrl.mem_write);

	always_ff @(posedge clk) begin
		if (i_reset)
			resp_seen <= 1'b0;
		else if (mem_bus.advance)
			resp_seen <= 1'b0;
		else if (access & i_data_response)
			resp_seen <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (i_data_response & ~resp_seen)
			held_rdata <= i_mem_rdata;
	end

	assign o_data_request = access & ~resp_seen;
	assign o_write_enable = o_data_request & mem_bus.ctrl.mem_write;
	assign mem_bus.ready = ~access | resp_seen | i_data_response;

	always_comb begin
		if (mem_bus.ctrl.mem_byte) begin
			o_mem_address = mem_bus.alu_data;
			o_mem_byte_enable = mem_bus.alu_data[0] ? 2'b10 : 2'b01;  // odd is the high byte
			o_write_data = {2{mem_bus.src_data[7:0]}};
		end else begin
			o_mem_address = {mem_bus.alu_data[15:1], 1'b0};
			o_mem_byte_enable = 2'b11;
			o_write_data = mem_bus.src_data;
		end
	end

	assign rdata = resp_seen ? held_rdata : i_mem_rdata;
	assign rbyte = mem_bus.alu_data[0] ? rdata[15:8] : rdata[7:0];
	assign mem_bus.mem_output = mem_bus.ctrl.mem_byte ? {8'h00, rbyte} : rdata;

endmodule

// File: cpu_datapath.sv
`timescale 1ns/1ns

module cpu_datapath import lc3b_types::*; (
	input  logic       clk,
	input  logic       i_reset,
	input  lc3b_word   i_instr,
	input  logic       i_instruction_response,
	input  lc3b_word   i_mem_rdata,
	input  logic       i_data_response,
	output lc3b_word   o_instruction_address,
	output logic       o_instruction_request,
	output lc3b_word   o_mem_address,
	output lc3b_word   o_write_data,
	output logic [1:0] o_mem_byte_enable,
	output logic       o_data_request,
	output logic       o_write_enable
);

	typedef struct packed {
		lc3b_control_word ctrl;
		logic             valid;
		lc3b_word         pc;  // already incremented
		lc3b_word         ir;
		lc3b_word         a;   // sr1, then alu result
		lc3b_word         b;   // sr2 or store data, then load data
	} stage_t;

	stage_t           ifid, idex, exmem, memwb;
	lc3b_control_word if_ctrl;
	lc3b_word         pc, pc_plus2, br_target;
	lc3b_word         reg_a, reg_b, fwd_a, fwd_b, mem_fwd, alu_b, alu_out, wb_data;
	lc3b_reg          id_src2, ex_src2;
	lc3b_nzp          cc, gen_cc;
	lc3b_fwd_sel      sel1, sel2, sel2_used;
	logic             fetch_en, advance, flush, load_regfile;

	mem_stage_if mem_bus ();

	assign pc_plus2 = pc + 16'd2;
	assign o_instruction_address = pc;
	assign o_instruction_request = fetch_en & ~flush;  // target fetch starts next cycle

	// taken branch in WB, everything younger is wrong path
	assign flush = memwb.valid & memwb.ctrl.is_branch & |(memwb.ir[11:9] & cc);
	assign br_target = memwb.pc + {{6{memwb.ir[8]}}, memwb.ir[8:0], 1'b0};
	// no fetch is needed while flushing
	assign advance = (i_instruction_response | flush) & mem_bus.ready;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			pc <= '0;
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			if (advance)
				pc <= flush ? br_target : pc_plus2;
		end
	end

	control_rom u_control_rom (.i_instr, .o_ctrl(if_ctrl));

	assign id_src2 = ifid.ctrl.store_src ? ifid.ir[11:9] : ifid.ir[2:0];

	regfile u_regfile (
		.clk, .i_reset,
		.i_load(load_regfile), .i_dest(memwb.ir[11:9]), .i_data(wb_data),
		.i_src_a(ifid.ir[8:6]), .i_src_b(id_src2),
		.o_reg_a(reg_a), .o_reg_b(reg_b)
	);

	assign ex_src2 = idex.ctrl.store_src ? idex.ir[11:9] : idex.ir[2:0];

	dataforward u_dataforward (
		.i_ex_src1(idex.ir[8:6]), .i_ex_src2(ex_src2),
		.i_mem_dest(exmem.ir[11:9]), .i_wb_dest(memwb.ir[11:9]),
		.i_mem_valid_dest(exmem.valid & exmem.ctrl.valid_dest),
		.i_wb_valid_dest(memwb.valid & memwb.ctrl.valid_dest),
		.o_sel1(sel1), .o_sel2(sel2)
	);

	// a load in MEM forwards its data straight from the port
	assign mem_fwd = (exmem.ctrl.regfile_sel == rf_mem) ? mem_bus.mem_output : exmem.a;

	always_comb begin
		case (sel1)
			fwd_mem: fwd_a = mem_fwd;
			fwd_wb:  fwd_a = wb_data;
			default: fwd_a = idex.a;
		endcase
		sel2_used = (idex.ctrl.uses_src2 | idex.ctrl.store_src) ? sel2 : fwd_none;
		case (sel2_used)
			fwd_mem: fwd_b = mem_fwd;
			fwd_wb:  fwd_b = wb_data;
			default: fwd_b = idex.b;
		endcase
		case (idex.ctrl.alu_b_sel)
			alub_reg:   alu_b = fwd_b;
			alub_imm5:  alu_b = {{11{idex.ir[4]}}, idex.ir[4:0]};
			alub_off6w: alu_b = {{9{idex.ir[5]}}, idex.ir[5:0], 1'b0};
			default:    alu_b = {{10{idex.ir[5]}}, idex.ir[5:0]};
		endcase
	end

	alu u_alu (.i_aluop(idex.ctrl.aluop), .i_a(fwd_a), .i_b(alu_b), .o_f(alu_out));

	assign mem_bus.ctrl = exmem.ctrl;
	assign mem_bus.valid = exmem.valid & ~flush;  // shadow store never reaches the port
	assign mem_bus.alu_data = exmem.a;
	assign mem_bus.src_data = exmem.b;
	assign mem_bus.advance = advance;

	mem_control u_mem_control (
		.clk, .i_reset, .mem_bus,
		.i_mem_rdata, .i_data_response,
		.o_mem_address, .o_write_data, .o_mem_byte_enable,
		.o_data_request, .o_write_enable
	);

	assign wb_data = (memwb.ctrl.regfile_sel == rf_mem) ? memwb.b : memwb.a;
	assign load_regfile = advance & memwb.valid & memwb.ctrl.load_regfile;

	always_comb begin
		if (wb_data[15])
			gen_cc = 3'b100;
		else if (wb_data == '0)
			gen_cc = 3'b010;
		else
			gen_cc = 3'b001;
	end

	always_ff @(posedge clk) begin
		if (i_reset)
			cc <= 3'b010;
		else if (advance & memwb.valid & memwb.ctrl.load_cc)
			cc <= gen_cc;
	end

	// every stage moves together on advance
	always_ff @(posedge clk) begin
		if (i_reset) begin
			ifid.valid <= 1'b0;
			idex.valid <= 1'b0;
			exmem.valid <= 1'b0;
			memwb.valid <= 1'b0;
		end else if (advance) begin
			ifid <= '{ctrl: if_ctrl, valid: ~flush, pc: pc_plus2, ir: i_instr, a: '0, b: '0};
			idex <= '{ctrl: ifid.ctrl, valid: ifid.valid & ~flush, pc: ifid.pc,
				ir: ifid.ir, a: reg_a, b: reg_b};
			exmem <= '{ctrl: idex.ctrl, valid: idex.valid & ~flush, pc: idex.pc,
				ir: idex.ir, a: alu_out, b: fwd_b};
			memwb <= '{ctrl: exmem.ctrl, valid: exmem.valid & ~flush, pc: exmem.pc,
				ir: exmem.ir, a: exmem.a, b: mem_bus.mem_output};
		end
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top import lc3b_types::*; (
	input  logic       clk,
	input  logic       i_reset,
	input  lc3b_word   i_instr,
	input  logic       i_instruction_response,
	input  lc3b_word   i_mem_rdata,
	input  logic       i_data_response,
	output lc3b_word   o_instruction_address,
	output logic       o_instruction_request,
	output lc3b_word   o_mem_address,
	output lc3b_word   o_write_data,
	output logic [1:0] o_mem_byte_enable,
	output logic       o_data_request,
	output logic       o_write_enable
);

	cpu_datapath u_cpu_datapath (
		.clk,
		.i_reset,
		.i_instr,                 // instruction port
		.i_instruction_response,
		.o_instruction_address,
		.o_instruction_request,
		.i_mem_rdata,             // data port
		.i_data_response,
		.o_mem_address,
		.o_write_data,
		.o_mem_byte_enable,
		.o_data_request,
		.o_write_enable
	);

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

	logic        clk = 1'b0;
	logic        i_reset = 1'b1;
	logic [15:0] i_instr = '0;
	logic        i_instruction_response = 1'b0;
	logic [15:0] i_mem_rdata = '0;
	logic        i_data_response = 1'b0;
	logic [15:0] o_instruction_address;
	logic        o_instruction_request;
	logic [15:0] o_mem_address;
	logic [15:0] o_write_data;
	logic [1:0]  o_mem_byte_enable;
	logic        o_data_request;
	logic        o_write_enable;

	logic [15:0] image [0:255];  // program, data memory, expected stores
	logic [31:0] rng_state = 32'h27f86c88;
	int          prog_len = 0;
	int          exp_count = 0;
	int          store_idx = 0;   // next expected store
	logic        fetch_busy = 1'b0;
	logic [15:0] fetch_addr = '0;
	int          fetch_wait = 0;
	logic        data_busy = 1'b0;
	int          data_wait = 0;
	logic        first_fetch_seen = 1'b0;

	cpu_top dut_i (
		.clk,
		.i_reset,
		.i_instr,
		.i_instruction_response,
		.i_mem_rdata,
		.i_data_response,
		.o_instruction_address,
		.o_instruction_request,
		.o_mem_address,
		.o_write_data,
		.o_mem_byte_enable,
		.o_data_request,
		.o_write_enable
	);

	always #2 clk = ~clk;  // 4 ns period

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// response delay of 0 to 2 cycles
	function automatic int pick_latency();
		return int'((next_random() >> 16) % 32'd3);
	endfunction

	task automatic flag_mismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("Error: %s expected 0x%h, got 0x%h at store %0d", name, expected, actual,
			store_idx);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_store();
		int base;
		assert (store_idx < exp_count) else
			abort_run("a store appeared after the last expected one");
		base = 129 + 3 * store_idx;  // address, data, byte enable
		assert (o_mem_address == image[base]) else
			flag_mismatch("o_mem_address", image[base], o_mem_address);
		assert (o_write_data == image[base + 1]) else
			flag_mismatch("o_write_data", image[base + 1], o_write_data);
		assert ({14'h0, o_mem_byte_enable} == image[base + 2]) else
			flag_mismatch("o_mem_byte_enable", image[base + 2], {14'h0, o_mem_byte_enable});
		store_idx++;
	endtask

	// instruction memory holds its response until the address moves on
	task automatic serve_fetch();
		if (!o_instruction_request) begin
			i_instruction_response = 1'b0;
			fetch_busy = 1'b0;
		end else begin
			if (!fetch_busy || o_instruction_address != fetch_addr) begin
				if (!first_fetch_seen) begin
					assert (o_instruction_address == 16'h0000) else
						flag_mismatch("o_instruction_address", 16'h0000, o_instruction_address);
					first_fetch_seen = 1'b1;
				end
				assert (o_instruction_address[15:7] == '0) else
					abort_run("instruction fetch outside the program memory");
				fetch_busy = 1'b1;
				fetch_addr = o_instruction_address;
				fetch_wait = pick_latency();
				i_instruction_response = 1'b0;
			end
			if (!i_instruction_response) begin
				if (fetch_wait == 0) begin
					i_instr = image[fetch_addr[6:1]];
					i_instruction_response = 1'b1;
				end else begin
					fetch_wait--;
				end
			end
		end
	endtask

	// data memory answers each access with one response pulse
	task automatic serve_data();
		int idx;
		i_data_response = 1'b0;
		if (!o_data_request) begin
			data_busy = 1'b0;
		end else begin
			if (!data_busy) begin
				data_busy = 1'b1;
				data_wait = pick_latency();
			end
			if (data_wait == 0) begin
				assert (o_mem_address[15:7] == '0) else
					abort_run("data access outside the data memory");
				idx = 64 + int'(o_mem_address[6:1]);
				i_mem_rdata = image[idx];
				if (o_write_enable) begin
					check_store();
					if (o_mem_byte_enable[0])
						image[idx][7:0] = o_write_data[7:0];
					if (o_mem_byte_enable[1])
						image[idx][15:8] = o_write_data[15:8];
				end
				i_data_response = 1'b1;
				data_busy = 1'b0;
			end else begin
				data_wait--;
			end
		end
	endtask

	always @(negedge clk) begin
		if (i_reset) begin
			i_instruction_response = 1'b0;
			i_data_response = 1'b0;
			fetch_busy = 1'b0;
			data_busy = 1'b0;
		end else begin
			serve_fetch();
			serve_data();
		end
	end

	initial begin
		$readmemh("cpu_testdata.hex", image);
		for (int i = 0; i < 64; i++) begin
			if (!$isunknown(image[i]))
				prog_len = i + 1;
		end
		exp_count = int'(image[128]);
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			assert (o_data_request === 1'b0 && o_write_enable === 1'b0) else
				abort_run("data port active during reset");
		end
		i_reset = 1'b0;
		@(posedge clk);
		@(negedge clk);
		assert (o_instruction_request === 1'b1) else
			abort_run("no instruction request in the first cycle after reset");
		wait (store_idx == exp_count);
		repeat (20) @(posedge clk);  // leave room for a stray store
		$display("all %0d stores matched", exp_count);
		$display("*** PASSED ***");
		$finish;
	end

	// watchdog budget of 40 cycles per program word times 3 for latency
	initial begin
		wait (prog_len != 0);
		repeat (prog_len * 40 * 3) @(posedge clk);
		$display("Timeout: the program did not finish, %0d of %0d stores seen", store_idx,
			exp_count);
		$display("*** FAILED ***");
		$fatal(1);
	end

endmodule

// File: cpu_testdata.hex
// words 00-3f program, 40-7f initial data memory, 80 number of expected stores,
// then one line per store: address, write data, byte enable
@00
1227 147D 1642 7608 58FE 9B3F 5D43 7A09 // add, and, not with forwarding
7C0A 780B 6200 1461 740C 2601 361B 2804 // load use, byte load and store
381A 6A0D 7A0E 0602 0803 721F 741F 761F // brzp falls through, brn over shadow stores
5FE0 0A01 0401 7E1F 1E23 7FD0 1FFF 03FD // brz taken, countdown loop
7E0F 0FFF 0000 0000 0000 0000           // loop exit store, halt, fetch pad
@40
A5C3 0007 80F1 1357 2468 0ACE 5F00 00FF
@80
000C
0010 000B 0003
0012 FFF5 0003
0014 0001 0003
0016 000A 0003
0018 A5C4 0003
001B A5A5 0002
001A F1F1 0001
001C A5F1 0003
0022 0003 0003
0022 0002 0003
0020 0001 0003
001E 0000 0003

// File: sim.f
lc3b_types.sv
mem_stage_if.sv
control_rom.sv
regfile.sv
alu.sv
dataforward.sv
mem_control.sv
cpu_datapath.sv
cpu_top.sv
tb_cpu.sv

// File: Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
